// File: common/rv_csr_pkg.sv
`default_nettype none
`include "rv_macros.svh"

package rv_csr_pkg;

	typedef enum logic [11:0] {
		CSR_MSTATUS = 12'h300,
		CSR_MTVEC   = 12'h305,
		CSR_MEPC    = 12'h341,
		CSR_MCAUSE  = 12'h342
	} csr_addr_e;

	// slot in the csr register array
	typedef logic [$clog2(`CSR_COUNT)-1:0] csr_idx_t;

	// NONE doubles as "no write"
	typedef enum logic [1:0] {
		CSR_NONE = 2'd0,
		CSR_RW   = 2'd1,
		CSR_RS   = 2'd2
	} csr_op_e;

endpackage

`default_nettype wire

// File: common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// bit positions in the one-hot inst_type
	localparam int TYPE_R = 0;
	localparam int TYPE_I = 1;
	localparam int TYPE_S = 2;
	localparam int TYPE_B = 3;
	localparam int TYPE_U = 4;
	localparam int TYPE_J = 5;

	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_XOR   = 4'd3,
		ALU_OR    = 4'd4,
		ALU_SRL   = 4'd5,
		ALU_SRA   = 4'd6,
		ALU_SLL   = 4'd7,
		ALU_LESS  = 4'd8,
		ALU_ULESS = 4'd9
	} alu_op_e;

endpackage

`default_nettype wire

// File: common/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path width
`define XLEN 32

// first pc after reset
`define RESET_PC 32'h8000_0000

// data memory size in bytes, power of two
`define DMEM_BYTES 256

// machine csrs
`define CSR_COUNT 4

`endif

// File: exu/exu.sv
`default_nettype none
`include "rv_macros.svh"

module exu
	import rv_isa_pkg::*;
(
	input  logic [6:0]       opcode,
	input  logic [`XLEN-1:0] src1,
	input  logic [`XLEN-1:0] src2,
	input  logic [`XLEN-1:0] imm,
	input  logic [5:0]       inst_type,
	input  logic [2:0]       funct3,
	input  logic [6:0]       funct7,
	input  logic [`XLEN-1:0] pc,
	input  logic [`XLEN-1:0] csr_val,
	output logic [`XLEN-1:0] val,
	output logic [`XLEN-1:0] jump_target,
	output logic             jump_taken,
	output logic [`XLEN-1:0] csr_wdata,
	output logic [3:0]       wmask
);

	logic [`XLEN-1:0] loperand;
	logic [`XLEN-1:0] roperand;
	alu_op_e          operator;
	logic [`XLEN:0]   diff;
	logic             op_less;
	logic             op_uless;
	logic [4:0]       shamt;
	logic [`XLEN:0]   cmp;
	logic             br_eq;
	logic             br_less;
	logic             br_uless;
	logic             br_cond;
	logic             is_jalr;

	always_comb begin
		case (opcode)
			OPC_LUI: begin
				loperand = '0;
				roperand = imm;
			end
			OPC_AUIPC: begin
				loperand = pc;
				roperand = imm;
			end
			OPC_JAL, OPC_JALR: begin
				loperand = pc; // link value
				roperand = `XLEN'd4;
			end
			OPC_OP: begin
				loperand = src1;
				roperand = src2;
			end
			OPC_OP_IMM, OPC_LOAD, OPC_STORE: begin
				loperand = src1;
				roperand = imm;
			end
			default: begin
				loperand = '0;
				roperand = '0;
			end
		endcase
	end

	// only OP and OP-IMM pick an operator from funct3
	always_comb begin
		operator = ALU_ADD;
		if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
			case (funct3)
				3'b000:  operator = (inst_type[TYPE_R] && funct7[5]) ? ALU_SUB : ALU_ADD;
				3'b001:  operator = ALU_SLL;
				3'b010:  operator = ALU_LESS;
				3'b011:  operator = ALU_ULESS;
				3'b100:  operator = ALU_XOR;
				3'b101:  operator = funct7[5] ? ALU_SRA : ALU_SRL;
				3'b110:  operator = ALU_OR;
				default: operator = ALU_AND;
			endcase
		end
	end

	assign diff     = {1'b0, loperand} - {1'b0, roperand};
	assign op_uless = diff[`XLEN]; // borrow out
	assign op_less  = (loperand[`XLEN-1] ^ roperand[`XLEN-1]) ? loperand[`XLEN-1] : diff[`XLEN-1];
	assign shamt    = roperand[4:0];

	always_comb begin
		case (operator)
			ALU_ADD:   val = loperand + roperand;
			ALU_SUB:   val = diff[`XLEN-1:0];
			ALU_AND:   val = loperand & roperand;
			ALU_XOR:   val = loperand ^ roperand;
			ALU_OR:    val = loperand | roperand;
			ALU_SRL:   val = loperand >> shamt;
			ALU_SRA:   val = $signed(loperand) >>> shamt;
			ALU_SLL:   val = loperand << shamt;
			ALU_LESS:  val = {{(`XLEN-1){1'b0}}, op_less};
			ALU_ULESS: val = {{(`XLEN-1){1'b0}}, op_uless};
			default:   val = '0;
		endcase
	end

	assign cmp      = {1'b0, src1} - {1'b0, src2};
	assign br_eq    = (src1 == src2);
	assign br_uless = cmp[`XLEN];
	assign br_less  = (src1[`XLEN-1] ^ src2[`XLEN-1]) ? src1[`XLEN-1] : cmp[`XLEN-1];

	always_comb begin
		case (funct3)
			3'b000:  br_cond = br_eq;
			3'b001:  br_cond = ~br_eq;
			3'b100:  br_cond = br_less;
			3'b101:  br_cond = ~br_less;
			3'b110:  br_cond = br_uless;
			3'b111:  br_cond = ~br_uless;
			default: br_cond = 1'b0;
		endcase
	end

	assign is_jalr     = (opcode == OPC_JALR);
	assign jump_target = is_jalr ? ((src1 + imm) & ~`XLEN'd1) : (pc + imm);
	assign jump_taken  = inst_type[TYPE_J] | is_jalr | (inst_type[TYPE_B] & br_cond);

	always_comb begin
		case (funct3[1:0])
			2'b00:   wmask = 4'h1;
			2'b01:   wmask = 4'h3;
			2'b10:   wmask = 4'hf;
			default: wmask = 4'h0;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b001:  csr_wdata = src1;           // csrrw
			3'b010:  csr_wdata = src1 | csr_val; // csrrs
			default: csr_wdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_csr_pkg.sv
rtl/idu.sv
exu/exu.sv
rtl/gpr_file.sv
rtl/csr_file.sv
rtl/lsu.sv
rtl/core_top.sv
testbench/core_tb.sv

// File: rtl/core_top.sv
`default_nettype none
`include "rv_macros.svh"

module core_top
	import rv_csr_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic [31:0]      inst,
	input  logic             inst_valid,
	output logic [`XLEN-1:0] pc,
	output logic             commit_valid,
	output logic [4:0]       commit_rd,
	output logic [`XLEN-1:0] commit_rd_data,
	output logic             commit_rd_we,
	output logic [`XLEN-1:0] commit_next_pc
);

	logic [6:0]       opcode;
	logic [5:0]       inst_type;
	logic [2:0]       funct3;
	logic [6:0]       funct7;
	logic [`XLEN-1:0] imm;
	logic [4:0]       rs1;
	logic [4:0]       rs2;
	logic [`XLEN-1:0] src1;
	logic [`XLEN-1:0] src2;
	logic             rd_we;
	logic [4:0]       rd;
	logic [`XLEN-1:0] rd_data;
	logic [`XLEN-1:0] val;
	logic [`XLEN-1:0] jump_target;
	logic             jump_taken;
	logic [`XLEN-1:0] csr_wdata;
	logic [`XLEN-1:0] csr_val;
	logic [11:0]      csr_addr;
	csr_op_e          csr_op;
	logic [3:0]       wmask;
	logic             mem_we;
	logic [`XLEN-1:0] load_data;

	idu idu_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.inst           (inst),
		.inst_valid     (inst_valid),
		.load_data      (load_data),
		.csr_val        (csr_val),
		.val            (val),
		.jump_taken     (jump_taken),
		.jump_target    (jump_target),
		.pc             (pc),
		.opcode         (opcode),
		.inst_type      (inst_type),
		.funct3         (funct3),
		.funct7         (funct7),
		.imm            (imm),
		.rs1            (rs1),
		.rs2            (rs2),
		.rd_we          (rd_we),
		.rd             (rd),
		.rd_data        (rd_data),
		.mem_we         (mem_we),
		.csr_addr       (csr_addr),
		.csr_op         (csr_op),
		.commit_valid   (commit_valid),
		.commit_rd      (commit_rd),
		.commit_rd_data (commit_rd_data),
		.commit_rd_we   (commit_rd_we),
		.commit_next_pc (commit_next_pc)
	);

	exu exu_i (
		.opcode      (opcode),
		.src1        (src1),
		.src2        (src2),
		.imm         (imm),
		.inst_type   (inst_type),
		.funct3      (funct3),
		.funct7      (funct7),
		.pc          (pc),
		.csr_val     (csr_val),
		.val         (val),
		.jump_target (jump_target),
		.jump_taken  (jump_taken),
		.csr_wdata   (csr_wdata),
		.wmask       (wmask)
	);

	gpr_file gpr_file_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1     (rs1),
		.rs2     (rs2),
		.rd_we   (rd_we),
		.rd      (rd),
		.rd_data (rd_data),
		.src1    (src1),
		.src2    (src2)
	);

	csr_file csr_file_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.csr_addr  (csr_addr),
		.csr_op    (csr_op),
		.csr_wdata (csr_wdata),
		.csr_val   (csr_val)
	);

	// address is src1 + imm from the exu adder
	lsu lsu_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (val),
		.store_data (src2),
		.wmask      (wmask),
		.mem_we     (mem_we),
		.funct3     (funct3),
		.load_data  (load_data)
	);

endmodule

`default_nettype wire

// File: rtl/csr_file.sv
`default_nettype none
`include "rv_macros.svh"

module csr_file
	import rv_csr_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic [11:0]      csr_addr,
	input  csr_op_e          csr_op,
	input  logic [`XLEN-1:0] csr_wdata,
	output logic [`XLEN-1:0] csr_val
);

	logic [`XLEN-1:0] csrs [`CSR_COUNT];
	csr_idx_t         idx;
	logic             hit;

	always_comb begin
		hit = 1'b1;
		idx = '0;
		case (csr_addr)
			CSR_MSTATUS: idx = csr_idx_t'(0);
			CSR_MTVEC:   idx = csr_idx_t'(1);
			CSR_MEPC:    idx = csr_idx_t'(2);
			CSR_MCAUSE:  idx = csr_idx_t'(3);
			default:     hit = 1'b0;
		endcase
	end

	assign csr_val = hit ? csrs[idx] : '0; // unknown reads 0

	// wdata already carries the OR for csrrs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CSR_COUNT; i++) begin
				csrs[i] <= '0;
			end
		end else if (hit && csr_op != CSR_NONE) begin
			csrs[idx] <= csr_wdata;
		end
	end

endmodule

`default_nettype wire

// File: rtl/gpr_file.sv
`default_nettype none
`include "rv_macros.svh"

module gpr_file (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [4:0]       rs1,
	input  logic [4:0]       rs2,
	input  logic             rd_we,
	input  logic [4:0]       rd,
	input  logic [`XLEN-1:0] rd_data,
	output logic [`XLEN-1:0] src1,
	output logic [`XLEN-1:0] src2
);

	logic [`XLEN-1:0] regs [32];

	assign src1 = regs[rs1];
	assign src2 = regs[rs2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_we && rd != 5'd0) begin // x0 stays zero
			regs[rd] <= rd_data;
		end
	end

endmodule

`default_nettype wire

// File: rtl/idu.sv
`default_nettype none
`include "rv_macros.svh"

module idu
	import rv_isa_pkg::*;
	import rv_csr_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic [31:0]      inst,
	input  logic             inst_valid,
	input  logic [`XLEN-1:0] load_data,
	input  logic [`XLEN-1:0] csr_val,
	input  logic [`XLEN-1:0] val,
	input  logic             jump_taken,
	input  logic [`XLEN-1:0] jump_target,
	output logic [`XLEN-1:0] pc,
	output logic [6:0]       opcode,
	output logic [5:0]       inst_type,
	output logic [2:0]       funct3,
	output logic [6:0]       funct7,
	output logic [`XLEN-1:0] imm,
	output logic [4:0]       rs1,
	output logic [4:0]       rs2,
	output logic             rd_we,
	output logic [4:0]       rd,
	output logic [`XLEN-1:0] rd_data,
	output logic             mem_we,
	output logic [11:0]      csr_addr,
	output csr_op_e          csr_op,
	output logic             commit_valid,
	output logic [4:0]       commit_rd,
	output logic [`XLEN-1:0] commit_rd_data,
	output logic             commit_rd_we,
	output logic [`XLEN-1:0] commit_next_pc
);

	logic             is_load;
	logic             is_csr;
	logic             writes_rd;
	logic [`XLEN-1:0] next_pc;

	assign opcode   = inst[6:0];
	assign rd       = inst[11:7];
	assign funct3   = inst[14:12];
	assign rs1      = inst[19:15];
	assign rs2      = inst[24:20];
	assign funct7   = inst[31:25];
	assign csr_addr = inst[31:20];

	always_comb begin
		inst_type = '0;
		case (opcode)
			OPC_OP:                                     inst_type[TYPE_R] = 1'b1;
			OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_SYSTEM: inst_type[TYPE_I] = 1'b1;
			OPC_STORE:                                  inst_type[TYPE_S] = 1'b1;
			OPC_BRANCH:                                 inst_type[TYPE_B] = 1'b1;
			OPC_LUI, OPC_AUIPC:                         inst_type[TYPE_U] = 1'b1;
			OPC_JAL:                                    inst_type[TYPE_J] = 1'b1;
			default: ; // unknown opcode, no format
		endcase
	end

	always_comb begin
		case (1'b1)
			inst_type[TYPE_I]: imm = {{20{inst[31]}}, inst[31:20]};
			inst_type[TYPE_S]: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			inst_type[TYPE_B]: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			inst_type[TYPE_U]: imm = {inst[31:12], 12'b0};
			inst_type[TYPE_J]: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default:           imm = '0;
		endcase
	end

	assign is_load = (opcode == OPC_LOAD);
	assign is_csr  = (opcode == OPC_SYSTEM) && (funct3 == 3'b001 || funct3 == 3'b010);

	// SYSTEM without a csr form writes nothing
	assign writes_rd = inst_type[TYPE_R] | inst_type[TYPE_U] | inst_type[TYPE_J]
		| (inst_type[TYPE_I] & ((opcode != OPC_SYSTEM) | is_csr));

	assign rd_we  = inst_valid & writes_rd;
	assign mem_we = inst_valid & inst_type[TYPE_S];
	assign csr_op = (inst_valid && is_csr) ? (funct3[1] ? CSR_RS : CSR_RW) : CSR_NONE;

	// csr forms return the old value
	assign rd_data = is_load ? load_data :
		is_csr ? csr_val :
		val;

	assign next_pc = jump_taken ? jump_target : pc + `XLEN'd4;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc           <= `RESET_PC;
			commit_valid <= 1'b0;
			commit_rd_we <= 1'b0;
		end else begin
			commit_valid <= inst_valid;
			commit_rd_we <= rd_we;
			if (inst_valid) begin
				pc <= next_pc;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid) begin
			commit_rd      <= rd;
			commit_rd_data <= rd_data;
			commit_next_pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

// File: rtl/lsu.sv
`default_nettype none
`include "rv_macros.svh"

module lsu (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [`XLEN-1:0] addr,
	input  logic [`XLEN-1:0] store_data,
	input  logic [3:0]       wmask,
	input  logic             mem_we,
	input  logic [2:0]       funct3,
	output logic [`XLEN-1:0] load_data
);

	localparam int AW = $clog2(`DMEM_BYTES);

	logic [7:0]       mem [`DMEM_BYTES];
	logic [AW-3:0]    word_idx;
	logic [1:0]       offset;
	logic [3:0]       bmask;
	logic [`XLEN-1:0] wdata;
	logic [`XLEN-1:0] word;
	logic [`XLEN-1:0] shifted;

	assign word_idx = addr[AW-1:2]; // wraps modulo memory size
	assign offset   = addr[1:0];
	assign bmask    = wmask << offset;
	assign wdata    = store_data << {offset, 3'b000};

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			word[8*i +: 8] = mem[{word_idx, 2'(i)}];
		end
	end

	assign shifted = word >> {offset, 3'b000};

	always_comb begin
		case (funct3)
			3'b000:  load_data = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};    // lb
			3'b001:  load_data = {{(`XLEN-16){shifted[15]}}, shifted[15:0]}; // lh
			3'b100:  load_data = {{(`XLEN-8){1'b0}}, shifted[7:0]};          // lbu
			3'b101:  load_data = {{(`XLEN-16){1'b0}}, shifted[15:0]};        // lhu
			default: load_data = shifted;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `DMEM_BYTES; i++) begin
				mem[i] <= '0;
			end
		end else if (mem_we) begin
			for (int i = 0; i < 4; i++) begin
				if (bmask[i]) begin
					mem[{word_idx, 2'(i)}] <= wdata[8*i +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module core_tb \
	-Mdir obj_dir \
	-f list.f

./obj_dir/Vcore_tb | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation passed"

// File: testbench/core_tb.sv
`default_nettype none
`include "rv_macros.svh"

module core_tb
	import rv_isa_pkg::*;
	import rv_csr_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ALU_COUNT = 200;
	// seeding + alu + x0, jumps, branches, memory, csrs
	localparam int N_INST = 62 + ALU_COUNT + 2 + 13 + 34 + 99 + 35;

	logic        clk;
	logic        rst_n;
	logic [31:0] inst;
	logic        inst_valid;
	logic [31:0] pc;
	logic        commit_valid;
	logic [4:0]  commit_rd;
	logic [31:0] commit_rd_data;
	logic        commit_rd_we;
	logic [31:0] commit_next_pc;

	// reference model state
	logic [31:0] m_regs [32];
	logic [7:0]  m_mem [`DMEM_BYTES];
	logic [31:0] m_csr [`CSR_COUNT];
	logic [31:0] m_pc;

	logic [4:0]  exp_rd_q [$];
	logic [31:0] exp_data_q [$];
	logic        exp_we_q [$];
	logic [31:0] exp_npc_q [$];

	int    seed = 32'he7b0_a57e;
	int    checks = 0;
	int    errors = 0;
	int    test_checks = 0;
	int    test_errors = 0;
	string test_name = "none";

	core_top core_top_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.inst           (inst),
		.inst_valid     (inst_valid),
		.pc             (pc),
		.commit_valid   (commit_valid),
		.commit_rd      (commit_rd),
		.commit_rd_data (commit_rd_data),
		.commit_rd_we   (commit_rd_we),
		.commit_next_pc (commit_next_pc)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	function automatic int csr_slot(input logic [11:0] addr);
		case (addr)
			CSR_MSTATUS: return 0;
			CSR_MTVEC:   return 1;
			CSR_MEPC:    return 2;
			CSR_MCAUSE:  return 3;
			default:     return -1;
		endcase
	endfunction

	// executes one instruction on the model, returns the expected commit
	function automatic void ref_exec(input logic [31:0] ins, output logic [4:0] e_rd,
		output logic [31:0] e_data, output logic e_we, output logic [31:0] e_npc);
		logic [6:0]  op;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] b2;
		logic [31:0] i_imm;
		logic [31:0] s_imm;
		logic [31:0] b_imm;
		logic [31:0] j_imm;
		logic [31:0] addr;
		logic [31:0] word;
		logic [31:0] old;
		logic        take;
		int          lin;
		int          off;
		int          base;
		int          nbytes;
		int          slot;

		op    = ins[6:0];
		f3    = ins[14:12];
		a     = m_regs[ins[19:15]];
		b     = m_regs[ins[24:20]];
		i_imm = {{20{ins[31]}}, ins[31:20]};
		s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		e_rd  = ins[11:7];
		e_we  = 1'b0;
		e_data = 32'h0;
		e_npc = m_pc + 32'd4;
		addr  = (op == OPC_STORE) ? a + s_imm : a + i_imm;
		lin   = int'(addr % `DMEM_BYTES);
		off   = int'(addr[1:0]);
		base  = lin - off;
		case (op)
			OPC_LUI: begin
				e_we   = 1'b1;
				e_data = {ins[31:12], 12'h000};
			end
			OPC_AUIPC: begin
				e_we   = 1'b1;
				e_data = m_pc + {ins[31:12], 12'h000};
			end
			OPC_JAL: begin
				e_we   = 1'b1;
				e_data = m_pc + 32'd4;
				e_npc  = m_pc + j_imm;
			end
			OPC_JALR: begin
				e_we   = 1'b1;
				e_data = m_pc + 32'd4;
				e_npc  = (a + i_imm) & 32'hffff_fffe;
			end
			OPC_BRANCH: begin
				case (f3)
					3'b000:  take = (a == b);
					3'b001:  take = (a != b);
					3'b100:  take = $signed(a) < $signed(b);
					3'b101:  take = $signed(a) >= $signed(b);
					3'b110:  take = a < b;
					3'b111:  take = a >= b;
					default: take = 1'b0;
				endcase
				if (take) begin
					e_npc = m_pc + b_imm;
				end
			end
			OPC_OP, OPC_OP_IMM: begin
				e_we = 1'b1;
				b2   = (op == OPC_OP) ? b : i_imm;
				case (f3)
					3'b000:  e_data = (op == OPC_OP && ins[30]) ? a - b2 : a + b2;
					3'b001:  e_data = a << b2[4:0];
					3'b010:  e_data = ($signed(a) < $signed(b2)) ? 32'd1 : 32'd0;
					3'b011:  e_data = (a < b2) ? 32'd1 : 32'd0;
					3'b100:  e_data = a ^ b2;
					3'b101: begin
						if (ins[30]) begin
							e_data = $signed(a) >>> b2[4:0]; // sign fill
						end else begin
							e_data = a >> b2[4:0];
						end
					end
					3'b110:  e_data = a | b2;
					default: e_data = a & b2;
				endcase
			end
			OPC_LOAD: begin
				e_we = 1'b1;
				for (int i = 0; i < 4; i++) begin
					word[8*i +: 8] = (off + i < 4) ? m_mem[base + off + i] : 8'h00; // stays in word
				end
				case (f3)
					3'b000:  e_data = {{24{word[7]}}, word[7:0]};
					3'b001:  e_data = {{16{word[15]}}, word[15:0]};
					3'b100:  e_data = {24'h0, word[7:0]};
					3'b101:  e_data = {16'h0, word[15:0]};
					default: e_data = word;
				endcase
			end
			OPC_STORE: begin
				nbytes = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
				for (int i = 0; i < nbytes; i++) begin
					if (off + i < 4) begin
						m_mem[base + off + i] = b[8*i +: 8];
					end
				end
			end
			OPC_SYSTEM: begin
				if (f3 == 3'b001 || f3 == 3'b010) begin
					slot   = csr_slot(ins[31:20]);
					old    = (slot >= 0) ? m_csr[slot] : 32'h0;
					e_we   = 1'b1;
					e_data = old;
					if (slot >= 0) begin
						m_csr[slot] = (f3 == 3'b001) ? a : (a | old);
					end
				end
			end
			default: ; // unknown, just pc + 4
		endcase
		if (e_we && e_rd != 5'd0) begin
			m_regs[e_rd] = e_data;
		end
		m_pc = e_npc;
	endfunction

	task automatic check_field(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		test_checks++;
		assert (actual == expected) else begin
			$display("CHECK FAILED %s %s: expected %h actual %h", test_name, field,
				expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic issue(input logic [31:0] ins);
		logic [4:0]  e_rd;
		logic [31:0] e_data;
		logic        e_we;
		logic [31:0] e_npc;
		@(negedge clk);
		ref_exec(ins, e_rd, e_data, e_we, e_npc);
		exp_rd_q.push_back(e_rd);
		exp_data_q.push_back(e_data);
		exp_we_q.push_back(e_we);
		exp_npc_q.push_back(e_npc);
		inst       = ins;
		inst_valid = 1'b1;
	endtask

	task automatic set_random_reg(input logic [4:0] rd);
		logic [31:0] r;
		r = $random(seed);
		issue(enc_u(r[31:12], rd, OPC_LUI));
		issue(enc_i(r[11:0], rd, 3'b000, rd, OPC_OP_IMM));
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic finish_test();
		@(negedge clk);
		inst_valid = 1'b0;
		inst       = 32'h0;
		@(posedge clk);
		while (exp_npc_q.size() != 0) begin
			@(posedge clk);
		end
		$display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
	endtask

	task automatic reset_test();
		start_test("reset");
		repeat (3) begin
			@(negedge clk);
			check_field("pc", `RESET_PC, pc);
			check_field("commit_valid", 32'h0, 32'(commit_valid));
			check_field("commit_rd_we", 32'h0, 32'(commit_rd_we));
		end
		finish_test();
	endtask

	task automatic alu_test();
		logic [31:0] r;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		start_test("alu");
		for (int k = 1; k < 32; k++) begin
			set_random_reg(5'(k));
		end
		for (int n = 0; n < ALU_COUNT; n++) begin
			r  = $random(seed);
			f3 = r[2:0];
			if (r[3]) begin
				f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[4]) ? 7'h20 : 7'h00;
				issue(enc_r(f7, r[9:5], r[14:10], f3, r[19:15]));
			end else begin
				imm = r[31:20];
				if (f3 == 3'b001) begin
					imm = {7'h00, r[24:20]};
				end
				if (f3 == 3'b101) begin
					imm = {r[4] ? 7'h20 : 7'h00, r[24:20]}; // srai or srli
				end
				issue(enc_i(imm, r[14:10], f3, r[19:15], OPC_OP_IMM));
			end
		end
		issue(enc_i(12'h07b, 5'd1, 3'b000, 5'd0, OPC_OP_IMM));
		issue(enc_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd7)); // x0 still zero
		finish_test();
	endtask

	task automatic jump_test();
		start_test("jumps");
		issue(enc_u(20'h12345, 5'd10, OPC_LUI));
		issue(enc_u(20'h00010, 5'd11, OPC_AUIPC));
		issue(enc_u(20'hfffff, 5'd12, OPC_AUIPC));
		issue(enc_j(21'h000010, 5'd1));
		issue(enc_j(21'h1ffff8, 5'd2));
		issue(enc_j(21'h000100, 5'd0));
		issue(enc_u(20'h80001, 5'd13, OPC_LUI));
		issue(enc_i(12'h123, 5'd13, 3'b000, 5'd13, OPC_OP_IMM)); // odd base
		issue(enc_i(12'h001, 5'd13, 3'b000, 5'd5, OPC_JALR));
		issue(enc_i(12'hffd, 5'd13, 3'b000, 5'd6, OPC_JALR));
		issue(enc_i(12'h008, 5'd13, 3'b000, 5'd13, OPC_JALR));
		issue(32'h0000_000b);
		issue(enc_r(7'h00, 5'd13, 5'd0, 3'b000, 5'd14));
		finish_test();
	endtask

	task automatic branch_test();
		logic [4:0] lhs [5];
		logic [4:0] rhs [5];
		start_test("branches");
		issue(enc_i(12'h005, 5'd0, 3'b000, 5'd20, OPC_OP_IMM));
		issue(enc_i(12'h005, 5'd0, 3'b000, 5'd21, OPC_OP_IMM));
		issue(enc_i(12'hffd, 5'd0, 3'b000, 5'd22, OPC_OP_IMM));
		issue(enc_i(12'h007, 5'd0, 3'b000, 5'd23, OPC_OP_IMM));
		// equal, signed less only, unsigned less only, both less, neither
		lhs = '{5'd20, 5'd22, 5'd20, 5'd20, 5'd23};
		rhs = '{5'd21, 5'd20, 5'd22, 5'd23, 5'd20};
		for (int f = 0; f < 8; f++) begin
			if (f != 2 && f != 3) begin
				for (int p = 0; p < 5; p++) begin
					issue(enc_b(p[0] ? 13'h1ff0 : 13'h0018, rhs[p], lhs[p], 3'(f)));
				end
			end
		end
		finish_test();
	endtask

	task automatic mem_test();
		start_test("loads and stores");
		issue(enc_i(12'h040, 5'd0, 3'b000, 5'd24, OPC_OP_IMM));
		for (int sz = 0; sz < 3; sz++) begin
			for (int off = 0; off < 4; off++) begin
				set_random_reg(5'd25);
				issue(enc_s(12'((sz * 4 + off) * 4 + off), 5'd25, 5'd24, 3'(sz)));
			end
		end
		for (int lf = 0; lf < 6; lf++) begin
			if (lf != 3) begin
				for (int w = 0; w < 12; w++) begin
					issue(enc_i(12'(w * 4 + w % 4), 5'd24, 3'(lf), 5'd26, OPC_LOAD));
				end
			end
		end
		issue(enc_u(20'h00010, 5'd27, OPC_LUI));
		issue(enc_i(12'h045, 5'd27, 3'b010, 5'd26, OPC_LOAD)); // wraps to 0x45
		finish_test();
	endtask

	task automatic csr_test();
		logic [11:0] addrs [5];
		start_test("csrs");
		addrs = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, 12'h7c0};
		for (int k = 0; k < 5; k++) begin
			set_random_reg(5'd8);
			issue(enc_i(addrs[k], 5'd8, 3'b001, 5'd9, OPC_SYSTEM));
			set_random_reg(5'd8);
			issue(enc_i(addrs[k], 5'd8, 3'b010, 5'd9, OPC_SYSTEM));
			issue(enc_i(addrs[k], 5'd0, 3'b010, 5'd9, OPC_SYSTEM)); // read back
		end
		finish_test();
	endtask

	// compares each commit with the oldest expected record
	initial begin
		logic [4:0]  e_rd;
		logic [31:0] e_data;
		logic        e_we;
		logic [31:0] e_npc;
		forever begin
			@(negedge clk);
			if (commit_valid) begin
				if (exp_npc_q.size() == 0) begin
					$display("ERROR in %s: a commit arrived with no instruction outstanding",
						test_name);
					errors++;
					test_errors++;
				end else begin
					e_rd   = exp_rd_q.pop_front();
					e_data = exp_data_q.pop_front();
					e_we   = exp_we_q.pop_front();
					e_npc  = exp_npc_q.pop_front();
					check_field("commit_rd", 32'(e_rd), 32'(commit_rd));
					check_field("commit_rd_we", 32'(e_we), 32'(commit_rd_we));
					if (e_we) begin
						check_field("commit_rd_data", e_data, commit_rd_data);
					end
					check_field("commit_next_pc", e_npc, commit_next_pc);
					check_field("pc", e_npc, pc);
				end
			end
		end
	end

	initial begin
		#(N_INST * 40 + 1000);
		$display("ERROR: timeout, an instruction never committed in test %s", test_name);
		$display("Test failed");
		$finish;
	end

	initial begin
		rst_n      = 1'b0;
		inst       = 32'h0;
		inst_valid = 1'b0;
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = 32'h0;
		end
		for (int i = 0; i < `DMEM_BYTES; i++) begin
			m_mem[i] = 8'h00;
		end
		for (int i = 0; i < `CSR_COUNT; i++) begin
			m_csr[i] = 32'h0;
		end
		m_pc = `RESET_PC;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		reset_test();
		alu_test();
		jump_test();
		branch_test();
		mem_test();
		csr_test();
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
